/* Bender.yml */
package:
  name: riscv_pipelined

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/rv_pipe_pkg.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/memory_stage.sv
  - verilog/hazard_unit.sv
  - verilog/riscv_pipelined.sv
  - target: simulation
    files:
      - dv/tb_riscv_pipelined.sv

/* build.f */
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard_unit.sv
verilog/riscv_pipelined.sv
dv/tb_riscv_pipelined.sv

/* dv/tb_riscv_pipelined.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_pipelined;

  // local instruction kinds, also index the reference model
  localparam int op_lui  = 0;
  localparam int op_addi = 1;
  localparam int op_add  = 2;
  localparam int op_sub  = 3;
  localparam int op_and  = 4;
  localparam int op_or   = 5;
  localparam int op_xor  = 6;
  localparam int op_slt  = 7;
  localparam int op_lw   = 8;
  localparam int op_sw   = 9;
  localparam int op_beq  = 10;
  localparam int op_bne  = 11;
  localparam int op_jal  = 12;
  localparam logic [31:0] boot_pc = 32'h0;
  localparam int timeout_cycles = 2000;

  logic clk;
  logic reset;
  wire [31:0] instr_addr;
  wire [31:0] instr_data;
  wire [31:0] data_addr;
  wire [31:0] data_wdata;
  wire [31:0] data_rdata;
  wire [3:0]  data_we;

  // 1 KiB each, word indexed
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] mdl_mem [0:255];

  // program as generated, one entry per instruction
  int          p_op  [0:255];
  int          p_rd  [0:255];
  int          p_rs1 [0:255];
  int          p_rs2 [0:255];
  logic [31:0] p_imm [0:255];
  int          n_instr;
  logic [31:0] final_pc;

  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] got_addr [$];
  logic [31:0] got_data [$];

  int seed;
  int test_errors;
  int total_errors;
  int tests_passed;
  int tests_failed;

  riscv_pipelined #(.reset_pc(boot_pc)) DUT
    ( .clk                       ( clk        )
    , .reset                     ( reset      )
    , .memory_instr__address     ( instr_addr )
    , .memory_instr__read_data   ( instr_data )
    , .memory_data__address      ( data_addr  )
    , .memory_data__write_data   ( data_wdata )
    , .memory_data__write_enable ( data_we    )
    , .memory_data__read_data    ( data_rdata )
    );

  always #10 clk = ~clk;

  // both memories answer in the same cycle
  assign instr_data = imem[instr_addr[9:2]];
  assign data_rdata = dmem[data_addr[9:2]];

  // data memory write and store log
  always @(posedge clk) begin
    if (data_we != 4'b0000) begin
      dmem[data_addr[9:2]] <= data_wdata;
      if (!reset) begin
        got_addr.push_back(data_addr);
        got_data.push_back(data_wdata);
      end
    end
  end

  function automatic int random_below(int n);
    return {$random(seed)} % n;
  endfunction

  // encode from the RV32I formats and record the fields for the model
  task automatic put_instr(int op, int rd, int rs1, int rs2, logic [31:0] imm);
    logic [31:0] w;
    logic [4:0]  d;
    logic [4:0]  a;
    logic [4:0]  b;
    d = rd;
    a = rs1;
    b = rs2;
    case (op)
      op_lui:  w = {imm[31:12], d, 7'h37};
      op_addi: w = {imm[11:0], a, 3'h0, d, 7'h13};
      op_add:  w = {7'h00, b, a, 3'h0, d, 7'h33};
      op_sub:  w = {7'h20, b, a, 3'h0, d, 7'h33};
      op_and:  w = {7'h00, b, a, 3'h7, d, 7'h33};
      op_or:   w = {7'h00, b, a, 3'h6, d, 7'h33};
      op_xor:  w = {7'h00, b, a, 3'h4, d, 7'h33};
      op_slt:  w = {7'h00, b, a, 3'h2, d, 7'h33};
      op_lw:   w = {imm[11:0], a, 3'h2, d, 7'h03};
      op_sw:   w = {imm[11:5], b, a, 3'h2, imm[4:0], 7'h23};
      op_beq:  w = {imm[12], imm[10:5], b, a, 3'h0, imm[4:1], imm[11], 7'h63};
      op_bne:  w = {imm[12], imm[10:5], b, a, 3'h1, imm[4:1], imm[11], 7'h63};
      default: w = {imm[20], imm[10:1], imm[11], imm[19:12], d, 7'h6f};
    endcase
    imem[n_instr]  = w;
    p_op[n_instr]  = op;
    p_rd[n_instr]  = rd;
    p_rs1[n_instr] = rs1;
    p_rs2[n_instr] = rs2;
    p_imm[n_instr] = imm;
    n_instr++;
  endtask

  // one of lui, addi or the register ops
  task automatic put_alu(int rd, int rs1, int rs2);
    int          op;
    logic [31:0] imm;
    op  = random_below(8);
    imm = $random(seed);
    if (op == op_lui) begin
      imm[11:0] = '0;
    end else begin
      imm = {{20{imm[11]}}, imm[11:0]};
    end
    put_instr(op, rd, rs1, rs2, imm);
  endtask

  // skipped slot after a branch or jump, stores make leaks visible
  task automatic put_filler();
    if (random_below(2) == 1) begin
      put_instr(op_sw, 0, 0, 1 + random_below(7), 32 + 4 * random_below(8));
    end else begin
      put_alu(random_below(8), random_below(8), random_below(8));
    end
  endtask

  task automatic build_program(int mode);
    int i;
    int kind;
    int a;
    int b;
    int k;
    logic [31:0] v;
    n_instr = 0;
    for (i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    // every register gets a known value first
    for (i = 1; i < 8; i++) begin
      v = $random(seed);
      put_instr(op_lui, i, 0, 0, {v[31:12], 12'h000});
      put_instr(op_addi, i, i, 0, {{20{v[11]}}, v[11:0]});
    end
    for (i = 0; i < 20; i++) begin
      kind = (mode == 6) ? 1 + random_below(5) : mode;
      case (kind)
        1: put_alu(random_below(8), random_below(8), random_below(8));
        2: begin
          // consumers at distance one and two
          a = 1 + random_below(7);
          put_alu(a, random_below(8), random_below(8));
          put_alu(1 + random_below(7), a, random_below(8));
          put_alu(1 + random_below(7), random_below(8), a);
        end
        3: begin
          // base below 192, load target differs from base
          a = 1 + random_below(7);
          b = a % 7 + 1;
          put_instr(op_addi, a, 0, 0, 4 * random_below(48));
          put_instr(op_lw, b, a, 0, 4 * random_below(16));
          put_instr(op_sw, 0, a, b, 4 * random_below(16));
          put_instr(op_add, random_below(8), b, random_below(8), 0);
        end
        4: begin
          k = 1 + random_below(3);
          a = random_below(8);
          b = (random_below(2) == 1) ? a : random_below(8);
          put_instr((random_below(2) == 1) ? op_beq : op_bne, 0, a, b, 4 * (k + 1));
          repeat (k) put_filler();
        end
        default: begin
          k = 1 + random_below(3);
          put_instr(op_jal, 1 + random_below(7), 0, 0, 4 * (k + 1));
          repeat (k) put_filler();
        end
      endcase
    end
    // dump x1..x7, then spin
    for (i = 1; i < 8; i++) begin
      put_instr(op_sw, 0, 0, i, 4 * i);
    end
    final_pc = 4 * n_instr;
    put_instr(op_jal, 0, 0, 0, 0);
  endtask

  task automatic fill_data_memory();
    int i;
    for (i = 0; i < 256; i++) begin
      dmem[i] = $random(seed);
    end
  endtask

  // sequential ISA model, builds the expected store list
  task automatic run_reference();
    logic [31:0] r [0:7];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ea;
    logic [31:0] pc;
    logic [31:0] nxt;
    bit          wr;
    int          i;
    for (i = 0; i < 8; i++) begin
      r[i] = '0;
    end
    for (i = 0; i < 256; i++) begin
      mdl_mem[i] = dmem[i];
    end
    exp_addr.delete();
    exp_data.delete();
    pc = boot_pc;
    while (pc != final_pc) begin
      i   = pc >> 2;
      a   = r[p_rs1[i]];
      b   = r[p_rs2[i]];
      ea  = a + p_imm[i];
      nxt = pc + 4;
      res = '0;
      wr  = 1'b1;
      case (p_op[i])
        op_lui:  res = p_imm[i];
        op_addi: res = ea;
        op_add:  res = a + b;
        op_sub:  res = a - b;
        op_and:  res = a & b;
        op_or:   res = a | b;
        op_xor:  res = a ^ b;
        op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_lw:   res = mdl_mem[ea[9:2]];
        op_sw: begin
          wr = 1'b0;
          mdl_mem[ea[9:2]] = b;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        op_beq: begin
          wr = 1'b0;
          if (a == b) nxt = pc + p_imm[i];
        end
        op_bne: begin
          wr = 1'b0;
          if (a != b) nxt = pc + p_imm[i];
        end
        default: begin
          res = pc + 4;
          nxt = pc + p_imm[i];
        end
      endcase
      if (wr && p_rd[i] != 0) r[p_rd[i]] = res;
      pc = nxt;
    end
  endtask

  task automatic check_reset_state(string where);
    if (data_we !== 4'b0000 || instr_addr !== boot_pc) begin
      $display("FAILED at %0t: %s, write enable %b, fetch address %h", $time, where,
               data_we, instr_addr);
      test_errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (3) begin
      @(posedge clk);
      #1 check_reset_state("during reset");
    end
    reset = 1'b0;
    #5 check_reset_state("first cycle after reset");
    got_addr.delete();
    got_data.delete();
  endtask

  // stop once the self-jump is fetched, the register dump stores are then in flight
  task automatic run_to_final_jump();
    int cycles;
    cycles = 0;
    while (instr_addr !== final_pc && cycles < timeout_cycles) begin
      @(posedge clk);
      #1 cycles++;
    end
    if (instr_addr !== final_pc) begin
      $display("ERROR: program did not reach its final jump before the second reset");
      test_errors++;
    end
  endtask

  // run to the final self-jump, then compare stores in order
  task automatic run_and_compare();
    int cycles;
    int i;
    cycles = 0;
    while (!(instr_addr == final_pc && got_addr.size() >= exp_addr.size())
           && cycles < timeout_cycles) begin
      @(posedge clk);
      #1 cycles++;
    end
    if (cycles >= timeout_cycles) begin
      $display("ERROR: program did not reach its final jump within %0d cycles",
               timeout_cycles);
      test_errors++;
    end
    if (got_addr.size() != exp_addr.size()) begin
      $display("FAILED at %0t: %0d stores seen, %0d expected", $time, got_addr.size(),
               exp_addr.size());
      test_errors++;
    end
    for (i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
      if (got_addr[i] !== exp_addr[i] || got_data[i] !== exp_data[i]) begin
        $display("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h", $time, i,
                 got_data[i], got_addr[i], exp_data[i], exp_addr[i]);
        test_errors++;
      end
    end
  endtask

  function automatic string test_name(int t);
    case (t)
      1: return "alu and immediates";
      2: return "dependent instructions";
      3: return "load use and store";
      4: return "branches and flush";
      5: return "jal and link";
      default: return "reset mid-program";
    endcase
  endfunction

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    seed         = 32'he0f9_2d0d;
    total_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    n_instr      = 0;
    for (int t = 1; t <= 6; t++) begin
      test_errors = 0;
      build_program(t);
      // last test: reset lands while the final stores are in flight
      if (t == 6) begin
        apply_reset();
        run_to_final_jump();
      end
      apply_reset();
      fill_data_memory();
      run_reference();
      run_and_compare();
      $display("test %0d %s: %0d stores, %0d errors", t, test_name(t), exp_addr.size(),
               test_errors);
      total_errors += test_errors;
      if (test_errors == 0) tests_passed++;
      else tests_failed++;
    end
    $display("tests run 6, passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
  ( input  wire            clk
  , input  wire            reset
  , input  wire            stall
  , input  wire            flush
  , input  wire if_to_id_t if_to_id
  , input  wire wb_t       wb
  , output id_to_ex_t      id_to_ex
  , output reg_idx_t       rs1
  , output reg_idx_t       rs2
  , output logic           uses_rs1
  , output logic           uses_rs2
  );

  if_to_id_t  if_id_q;
  // x0 has no storage
  data_t      regs [1:31];
  instr_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  data_t      imm_i;
  data_t      imm_s;
  data_t      imm_b;
  data_t      imm_u;
  data_t      imm_j;
  logic       legal;
  logic       need_rs1;
  logic       need_rs2;
  logic       writes_rd;
  data_t      rs1_val;
  data_t      rs2_val;

  // IF/ID register, flush wins over stall
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      if_id_q.valid <= 1'b0;
    end else if (!stall) begin
      if_id_q <= if_to_id;
    end
  end

  always_ff @(posedge clk) begin
    if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // read with write-through from writeback
  function automatic data_t read_reg(reg_idx_t idx);
    data_t value;
    if (idx == '0) begin
      value = '0;
    end else if (wb.we && wb.rd == idx) begin
      value = wb.data;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  assign instr  = if_id_q.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // immediates for every format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    rs1_val = read_reg(rs1);
    rs2_val = read_reg(rs2);
  end

  always_comb begin
    legal                = 1'b0;
    need_rs1             = 1'b0;
    need_rs2             = 1'b0;
    writes_rd            = 1'b0;
    id_to_ex.imm         = imm_i;
    id_to_ex.alu_op      = ALU_ADD;
    id_to_ex.alu_src_imm = 1'b0;
    id_to_ex.is_load     = 1'b0;
    id_to_ex.is_store    = 1'b0;
    id_to_ex.is_branch   = 1'b0;
    id_to_ex.branch_ne   = funct3 == F3_BNE;
    id_to_ex.is_jal      = 1'b0;
    case (opcode)
      OPC_LUI: begin
        legal                = 1'b1;
        writes_rd            = 1'b1;
        id_to_ex.imm         = imm_u;
        id_to_ex.alu_op      = ALU_PASS_B;
        id_to_ex.alu_src_imm = 1'b1;
      end
      OPC_OP_IMM: begin
        // addi only
        legal                = funct3 == F3_ADD_SUB;
        need_rs1             = 1'b1;
        writes_rd            = 1'b1;
        id_to_ex.alu_src_imm = 1'b1;
      end
      OPC_OP: begin
        need_rs1  = 1'b1;
        need_rs2  = 1'b1;
        writes_rd = 1'b1;
        legal     = funct7 == F7_BASE;
        case (funct3)
          F3_ADD_SUB: begin
            legal           = funct7 == F7_BASE || funct7 == F7_SUB;
            id_to_ex.alu_op = funct7 == F7_SUB ? ALU_SUB : ALU_ADD;
          end
          F3_SLT: id_to_ex.alu_op = ALU_SLT;
          F3_XOR: id_to_ex.alu_op = ALU_XOR;
          F3_OR:  id_to_ex.alu_op = ALU_OR;
          F3_AND: id_to_ex.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        legal                = funct3 == F3_WORD;
        need_rs1             = 1'b1;
        writes_rd            = 1'b1;
        id_to_ex.alu_src_imm = 1'b1;
        id_to_ex.is_load     = 1'b1;
      end
      OPC_STORE: begin
        legal                = funct3 == F3_WORD;
        need_rs1             = 1'b1;
        need_rs2             = 1'b1;
        id_to_ex.imm         = imm_s;
        id_to_ex.alu_src_imm = 1'b1;
        id_to_ex.is_store    = 1'b1;
      end
      OPC_BRANCH: begin
        legal              = funct3 == F3_BEQ || funct3 == F3_BNE;
        need_rs1           = 1'b1;
        need_rs2           = 1'b1;
        id_to_ex.imm       = imm_b;
        id_to_ex.is_branch = 1'b1;
      end
      OPC_JAL: begin
        legal           = 1'b1;
        writes_rd       = 1'b1;
        id_to_ex.imm    = imm_j;
        id_to_ex.is_jal = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    // unsupported words travel as bubbles
    id_to_ex.valid     = if_id_q.valid && legal;
    id_to_ex.pc        = if_id_q.pc;
    id_to_ex.rs1_val   = rs1_val;
    id_to_ex.rs2_val   = rs2_val;
    id_to_ex.rd        = rd;
    // x0 is never a write target
    id_to_ex.reg_write = id_to_ex.valid && writes_rd && rd != '0;
  end

  assign uses_rs1 = id_to_ex.valid && need_rs1;
  assign uses_rs2 = id_to_ex.valid && need_rs2;

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
  ( input  wire            clk
  , input  wire            reset
  , input  wire            stall
  , input  wire            flush
  , input  wire id_to_ex_t id_to_ex
  , output ex_to_mem_t     ex_to_mem
  , output logic           redirect
  , output addr_t          redirect_target
  , output reg_idx_t       ex_rd
  , output logic           ex_reg_write
  );

  id_to_ex_t id_ex_q;
  data_t     op_a;
  data_t     op_b;
  data_t     alu_result;
  logic      operands_equal;
  logic      branch_taken;

  // ID/EX register, bubble on stall or flush
  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex_q.valid <= 1'b0;
    end else if (stall || flush) begin
      id_ex_q.valid <= 1'b0;
    end else begin
      id_ex_q <= id_to_ex;
    end
  end

  assign op_a = id_ex_q.rs1_val;
  assign op_b = id_ex_q.alu_src_imm ? id_ex_q.imm : id_ex_q.rs2_val;

  always_comb begin
    case (id_ex_q.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      // signed compare
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // beq/bne compare the two register values
  assign operands_equal = id_ex_q.rs1_val == id_ex_q.rs2_val;
  assign branch_taken   = id_ex_q.is_branch && (operands_equal ^ id_ex_q.branch_ne);

  assign redirect        = id_ex_q.valid && (branch_taken || id_ex_q.is_jal);
  assign redirect_target = id_ex_q.pc + id_ex_q.imm;

  // destination seen by the hazard unit
  assign ex_rd        = id_ex_q.rd;
  assign ex_reg_write = id_ex_q.valid && id_ex_q.reg_write;

  assign ex_to_mem.valid      = id_ex_q.valid;
  assign ex_to_mem.alu_result = alu_result;
  assign ex_to_mem.store_data = id_ex_q.rs2_val;
  assign ex_to_mem.rd         = id_ex_q.rd;
  assign ex_to_mem.is_load    = id_ex_q.is_load;
  assign ex_to_mem.is_store   = id_ex_q.is_store;
  assign ex_to_mem.is_jal     = id_ex_q.is_jal;
  assign ex_to_mem.reg_write  = ex_reg_write;
  assign ex_to_mem.link       = id_ex_q.pc + 32'd4;

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
  #(parameter addr_t reset_pc = '0)
  ( input  wire         clk
  , input  wire         reset
  , input  wire         stall
  , input  wire         redirect
  , input  wire addr_t  redirect_target
  , output addr_t       instr_address
  , input  wire instr_t instr_read_data
  , output if_to_id_t   if_to_id
  );

  addr_t pc_q;

  // redirect from execute beats a stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= reset_pc;
    end else if (redirect) begin
      pc_q <= redirect_target;
    end else if (!stall) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign instr_address = pc_q;

  // memory answers in the same cycle
  assign if_to_id.valid = 1'b1;
  assign if_to_id.pc    = pc_q;
  assign if_to_id.instr = instr_read_data;

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit
  import rv_isa_pkg::*;
  ( input  wire reg_idx_t rs1
  , input  wire reg_idx_t rs2
  , input  wire           uses_rs1
  , input  wire           uses_rs2
  , input  wire reg_idx_t ex_rd
  , input  wire reg_idx_t mem_rd
  , input  wire           ex_reg_write
  , input  wire           mem_reg_write
  , input  wire           redirect
  , output logic          stall
  , output logic          flush
  );

  logic rs1_hit;
  logic rs2_hit;

  // no forwarding, so wait until the producer reaches writeback
  always_comb begin
    rs1_hit = uses_rs1 &&
              ((ex_reg_write && ex_rd == rs1) || (mem_reg_write && mem_rd == rs1));
    rs2_hit = uses_rs2 &&
              ((ex_reg_write && ex_rd == rs2) || (mem_reg_write && mem_rd == rs2));
  end

  // taken branch or jal kills both younger slots
  assign flush = redirect;
  // a stalled instruction behind a redirect is squashed anyway
  assign stall = (rs1_hit || rs2_hit) && !redirect;

endmodule

`default_nettype wire

/* verilog/memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
  ( input  wire             clk
  , input  wire             reset
  , input  wire ex_to_mem_t ex_to_mem
  , output addr_t           data_address
  , output data_t           data_write_data
  , output logic [3:0]      data_write_enable
  , input  wire data_t      data_read_data
  , output reg_idx_t        mem_rd
  , output logic            mem_reg_write
  , output wb_t             wb
  );

  ex_to_mem_t ex_mem_q;
  mem_to_wb_t mem_wb_q;

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_q.valid <= 1'b0;
    end else begin
      ex_mem_q <= ex_to_mem;
    end
  end

  // address and data always driven, enable only for a live store
  assign data_address      = ex_mem_q.alu_result;
  assign data_write_data   = ex_mem_q.store_data;
  assign data_write_enable = (ex_mem_q.valid && ex_mem_q.is_store) ? 4'b1111 : 4'b0000;

  assign mem_rd        = ex_mem_q.rd;
  assign mem_reg_write = ex_mem_q.valid && ex_mem_q.reg_write;

  // MEM/WB register picks load data, link or alu result
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb_q.valid <= 1'b0;
    end else begin
      mem_wb_q.valid     <= ex_mem_q.valid;
      mem_wb_q.rd        <= ex_mem_q.rd;
      mem_wb_q.reg_write <= mem_reg_write;
      if (ex_mem_q.is_load) begin
        mem_wb_q.result <= data_read_data;
      end else if (ex_mem_q.is_jal) begin
        mem_wb_q.result <= ex_mem_q.link;
      end else begin
        mem_wb_q.result <= ex_mem_q.alu_result;
      end
    end
  end

  assign wb.we   = mem_wb_q.valid && mem_wb_q.reg_write;
  assign wb.rd   = mem_wb_q.rd;
  assign wb.data = mem_wb_q.result;

endmodule

`default_nettype wire

/* verilog/riscv_pipelined.sv */
`timescale 1ns/10ps
`default_nettype none

// five-stage in-order core with split instruction and data ports
module riscv_pipelined
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
  #(parameter addr_t reset_pc = '0)
  ( input  wire         clk
  , input  wire         reset

  // instruction port
  , output addr_t       memory_instr__address
  , input  wire instr_t memory_instr__read_data

  // data port
  , output addr_t       memory_data__address
  , output data_t       memory_data__write_data
  , output logic  [3:0] memory_data__write_enable
  , input  wire data_t  memory_data__read_data
  );

  if_to_id_t  if_to_id;
  id_to_ex_t  id_to_ex;
  ex_to_mem_t ex_to_mem;
  wb_t        wb;

  // hazard unit inputs and outputs
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     uses_rs1;
  logic     uses_rs2;
  reg_idx_t ex_rd;
  reg_idx_t mem_rd;
  logic     ex_reg_write;
  logic     mem_reg_write;
  logic     stall;
  logic     flush;

  // control flow resolved in execute
  logic  redirect;
  addr_t redirect_target;

  fetch_stage #(.reset_pc(reset_pc)) fetch
    ( .clk             ( clk                     )
    , .reset           ( reset                   )
    , .stall           ( stall                   )
    , .redirect        ( redirect                )
    , .redirect_target ( redirect_target         )
    , .instr_address   ( memory_instr__address   )
    , .instr_read_data ( memory_instr__read_data )
    , .if_to_id        ( if_to_id                )
    );

  decode_stage decode
    ( .clk      ( clk      )
    , .reset    ( reset    )
    , .stall    ( stall    )
    , .flush    ( flush    )
    , .if_to_id ( if_to_id )
    , .wb       ( wb       )
    , .id_to_ex ( id_to_ex )
    , .rs1      ( rs1      )
    , .rs2      ( rs2      )
    , .uses_rs1 ( uses_rs1 )
    , .uses_rs2 ( uses_rs2 )
    );

  execute_stage execute
    ( .clk             ( clk             )
    , .reset           ( reset           )
    , .stall           ( stall           )
    , .flush           ( flush           )
    , .id_to_ex        ( id_to_ex        )
    , .ex_to_mem       ( ex_to_mem       )
    , .redirect        ( redirect        )
    , .redirect_target ( redirect_target )
    , .ex_rd           ( ex_rd           )
    , .ex_reg_write    ( ex_reg_write    )
    );

  memory_stage memory
    ( .clk               ( clk                       )
    , .reset             ( reset                     )
    , .ex_to_mem         ( ex_to_mem                 )
    , .data_address      ( memory_data__address      )
    , .data_write_data   ( memory_data__write_data   )
    , .data_write_enable ( memory_data__write_enable )
    , .data_read_data    ( memory_data__read_data    )
    , .mem_rd            ( mem_rd                    )
    , .mem_reg_write     ( mem_reg_write             )
    , .wb                ( wb                        )
    );

  hazard_unit hazard
    ( .rs1           ( rs1           )
    , .rs2           ( rs2           )
    , .uses_rs1      ( uses_rs1      )
    , .uses_rs2      ( uses_rs2      )
    , .ex_rd         ( ex_rd         )
    , .mem_rd        ( mem_rd        )
    , .ex_reg_write  ( ex_reg_write  )
    , .mem_reg_write ( mem_reg_write )
    , .redirect      ( redirect      )
    , .stall         ( stall         )
    , .flush         ( flush         )
    );

endmodule

`default_nettype wire

/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // byte address as seen on both memory ports
  typedef logic [31:0] addr_t;
  // register or memory word
  typedef logic [31:0] data_t;
  // architectural register number
  typedef logic [4:0] reg_idx_t;
  // raw fetched instruction word
  typedef logic [31:0] instr_t;

  // major opcodes the core understands
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // funct3 of register and immediate arithmetic
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLT     = 3'b010,
    F3_XOR     = 3'b100,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } alu_funct3_e;

  // funct3 of branches and word accesses
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_WORD = 3'b010
  } ctl_funct3_e;

  // funct7 for OP, sub flips bit 30
  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_SUB  = 7'b0100000
  } funct7_e;

  // operations the execute alu can do
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

endpackage

`default_nettype wire

/* verilog/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // fetched word paired with its pc
  typedef struct packed {
    logic   valid;
    addr_t  pc;
    instr_t instr;
  } if_to_id_t;

  // decoded instruction with operands already read
  typedef struct packed {
    logic     valid;
    addr_t    pc;
    data_t    rs1_val;
    data_t    rs2_val;
    data_t    imm;
    reg_idx_t rd;
    alu_op_e  alu_op;
    // operand b comes from imm instead of rs2
    logic     alu_src_imm;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    // bne when set, beq otherwise
    logic     branch_ne;
    logic     is_jal;
    logic     reg_write;
  } id_to_ex_t;

  // alu result doubles as the data address
  typedef struct packed {
    logic     valid;
    data_t    alu_result;
    data_t    store_data;
    reg_idx_t rd;
    logic     is_load;
    logic     is_store;
    logic     is_jal;
    logic     reg_write;
    // pc + 4 for jal
    data_t    link;
  } ex_to_mem_t;

  // final result waiting for the register file
  typedef struct packed {
    logic     valid;
    data_t    result;
    reg_idx_t rd;
    logic     reg_write;
  } mem_to_wb_t;

  // register file write port
  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    data_t    data;
  } wb_t;

endpackage

`default_nettype wire
